//--- include/adc_ctrl_config.svh
`ifndef ADC_CTRL_CONFIG_SVH
`define ADC_CTRL_CONFIG_SVH

// Width of the channel field in commands, responses and chsel
`define ADC_CHAN_W      5

// Width of one conversion result from the hard block
`define ADC_DATA_W      12

// Channel code that asks for a recalibration instead of a conversion
`define ADC_CH_RCLB     5'd31

// Channel code of the on-die temperature sensor
`define ADC_CH_TS       5'd17

// Dummy channel presented while idle or while flushing the last result
`define ADC_CH_IDLE     5'd30

// The power-down timer is wide enough to reach the tsen phase bit
`define ADC_TIMER_W     8

// Timer bit that closes the first power-down phase (64 cycles)
`define ADC_PWRDN_BIT   6

// Timer bit that closes the tsen settling phase (128 cycles)
`define ADC_TSEN_BIT    7

`endif

//--- verilog/adc_ctrl_pkg.sv
`include "adc_ctrl_config.svh"

package adc_ctrl_pkg;

    // One conversion request from the client
    // The packet markers travel with the command and come back in the response
    typedef struct packed {
        logic [`ADC_CHAN_W-1:0] channel;
        logic                   sop;
        logic                   eop;
    } adc_cmd_t;

    // One conversion result towards the client
    // All fields stay zero in cycles where valid is low
    typedef struct packed {
        logic                   valid;
        logic [`ADC_CHAN_W-1:0] channel;
        logic [`ADC_DATA_W-1:0] data;
        logic                   sop;
        logic                   eop;
    } adc_rsp_t;

    // Control pins of the ADC hard block
    typedef struct packed {
        logic [`ADC_CHAN_W-1:0] chsel;
        logic                   soc;
        logic                   usr_pwd;
        logic                   tsen;
    } adc_hb_ctrl_t;

    // Sequencer states, encoded contiguously so the last one bounds the legal range
    typedef enum logic [4:0] {
        PWRDWN         = 5'd0,
        PWRDWN_TSEN    = 5'd1,
        PWRDWN_DONE    = 5'd2,
        PWRUP_CH       = 5'd3,
        PWRUP_SOC      = 5'd4,
        WAIT           = 5'd5,
        GETCMD_W       = 5'd6,
        PRE_CONV       = 5'd7,
        GETCMD         = 5'd8,
        CONV           = 5'd9,
        CONV_DLY1      = 5'd10,
        PUTRESP        = 5'd11,
        PUTRESP_DLY1   = 5'd12,
        PUTRESP_DLY2   = 5'd13,
        PUTRESP_DLY3   = 5'd14,
        WAIT_PEND      = 5'd15,
        WAIT_PEND_DLY1 = 5'd16,
        PUTRESP_PEND   = 5'd17
    } adc_state_e;

endpackage

//--- verilog/adc_edge_sync.sv
`timescale 1ns/1ps

module adc_edge_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic clk_dft,
    input  logic eoc,
    output logic dft_rise,
    output logic dft_fall,
    output logic eoc_fall
);

    // Bit 0 carries clk_dft and bit 1 carries eoc through the same stages
    logic [1:0] meta_q;
    logic [1:0] sync_q;
    logic [1:0] last_q;

    // Both hard-block signals are asynchronous to clk
    // two flops settle them before any decision is made on them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta_q <= 2'b00;
            sync_q <= 2'b00;
        end else begin
            meta_q <= {eoc, clk_dft};
            sync_q <= meta_q;
        end
    end

    // The edge pulses are registered so each arrives three cycles after the raw edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q   <= 2'b00;
            dft_rise <= 1'b0;
            dft_fall <= 1'b0;
            eoc_fall <= 1'b0;
        end else begin
            last_q   <= sync_q;
            dft_rise <= sync_q[0] & ~last_q[0];
            dft_fall <= ~sync_q[0] & last_q[0];
            eoc_fall <= ~sync_q[1] & last_q[1];
        end
    end

    // Opposite clk_dft edges must never be reported together
    a_dft_edges_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(dft_rise && dft_fall)
    );

endmodule

//--- verilog/adc_seq_fsm.sv
`timescale 1ns/1ps
`include "adc_ctrl_config.svh"

module adc_seq_fsm (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_valid,
    input  adc_ctrl_pkg::adc_cmd_t     cmd,
    input  logic                       dft_rise,
    input  logic                       dft_fall,
    input  logic                       eoc_fall,
    output adc_ctrl_pkg::adc_hb_ctrl_t hb,
    output logic                       hold_cmd,
    output logic                       load_sample,
    output logic                       load_rsp,
    output logic                       last_ts
);

    import adc_ctrl_pkg::*;

    adc_state_e              state_q;
    adc_state_e              state_nxt;
    adc_hb_ctrl_t            hb_nxt;
    logic [`ADC_TIMER_W-1:0] timer_q;
    logic                    timer_clr;
    logic                    timer_inc;
    logic                    enter_pwrdwn;
    logic                    leave_pwrup;
    logic                    cmd_fetched;
    logic                    pend;
    logic                    conv_done_q;
    logic                    sample_due;
    logic                    cmd_is_rclb;
    logic                    cmd_is_ts;
    logic                    change_mode;

    // Command decode is only looked at in states where the command is held stable
    assign cmd_is_rclb = (cmd.channel == `ADC_CH_RCLB);
    assign cmd_is_ts   = (cmd.channel == `ADC_CH_TS);
    assign change_mode = last_ts ^ cmd_is_ts;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= PWRDWN;
        end else begin
            state_q <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            PWRDWN: begin
                if (timer_q[`ADC_PWRDN_BIT]) begin
                    state_nxt = PWRDWN_TSEN;
                end
            end
            PWRDWN_TSEN: begin
                if (timer_q[`ADC_TSEN_BIT]) begin
                    state_nxt = PWRDWN_DONE;
                end
            end
            // Power-up is aligned to a full clk_dft period of the hard block
            PWRDWN_DONE: begin
                if (dft_rise) begin
                    state_nxt = PWRUP_CH;
                end
            end
            PWRUP_CH: begin
                if (dft_fall) begin
                    state_nxt = PWRUP_SOC;
                end
            end
            // The first eoc after soc marks the block as running
            PWRUP_SOC: begin
                if (eoc_fall) begin
                    if (cmd_fetched && !cmd_is_rclb) begin
                        state_nxt = CONV;
                    end else if (cmd_fetched) begin
                        state_nxt = PUTRESP;
                    end else if (cmd_valid) begin
                        state_nxt = GETCMD;
                    end else begin
                        state_nxt = WAIT;
                    end
                end
            end
            WAIT: begin
                if (cmd_valid) begin
                    state_nxt = GETCMD_W;
                end
            end
            GETCMD_W: begin
                if (cmd_is_rclb || change_mode) begin
                    state_nxt = PWRDWN;
                end else begin
                    state_nxt = PRE_CONV;
                end
            end
            // Coming from idle the channel is switched on a conversion boundary
            PRE_CONV: begin
                if (eoc_fall) begin
                    state_nxt = CONV;
                end
            end
            // An owed result is flushed before a power-down cycle may start
            GETCMD: begin
                if ((cmd_is_rclb || change_mode) && pend) begin
                    state_nxt = WAIT_PEND;
                end else if (cmd_is_rclb || change_mode) begin
                    state_nxt = PWRDWN;
                end else begin
                    state_nxt = CONV;
                end
            end
            CONV: begin
                if (eoc_fall) begin
                    state_nxt = CONV_DLY1;
                end
            end
            CONV_DLY1: begin
                state_nxt = PUTRESP;
            end
            PUTRESP: begin
                state_nxt = PUTRESP_DLY1;
            end
            PUTRESP_DLY1: begin
                state_nxt = PUTRESP_DLY2;
            end
            PUTRESP_DLY2: begin
                state_nxt = PUTRESP_DLY3;
            end
            // The client has seen cmd_ready by now and may present the next command
            PUTRESP_DLY3: begin
                if (cmd_valid) begin
                    state_nxt = GETCMD;
                end else if (pend) begin
                    state_nxt = WAIT_PEND;
                end else begin
                    state_nxt = WAIT;
                end
            end
            WAIT_PEND: begin
                if (eoc_fall) begin
                    state_nxt = WAIT_PEND_DLY1;
                end
            end
            WAIT_PEND_DLY1: begin
                state_nxt = PUTRESP_PEND;
            end
            PUTRESP_PEND: begin
                if (cmd_valid) begin
                    state_nxt = GETCMD;
                end else begin
                    state_nxt = WAIT;
                end
            end
            default: begin
                state_nxt = PWRDWN;
            end
        endcase
    end

    // Hard-block pins follow the state being entered so they change with the state
    always_comb begin
        hb_nxt = hb;
        case (state_nxt)
            PWRDWN: begin
                hb_nxt.soc     = 1'b0;
                hb_nxt.usr_pwd = 1'b1;
            end
            // tsen only changes while the block is powered down
            PWRDWN_TSEN: begin
                hb_nxt.soc     = 1'b0;
                hb_nxt.usr_pwd = 1'b1;
                if (cmd_fetched && cmd_is_ts) begin
                    hb_nxt.tsen = 1'b1;
                end else if (!(cmd_fetched && cmd_is_rclb)) begin
                    hb_nxt.tsen = 1'b0;
                end
            end
            PWRDWN_DONE: begin
                hb_nxt.soc     = 1'b0;
                hb_nxt.usr_pwd = 1'b0;
            end
            PWRUP_CH: begin
                hb_nxt.chsel   = `ADC_CH_IDLE;
                hb_nxt.usr_pwd = 1'b0;
            end
            PWRUP_SOC: begin
                hb_nxt.soc = 1'b1;
            end
            CONV, CONV_DLY1: begin
                hb_nxt.chsel = cmd.channel;
            end
            // A dummy channel keeps a stale channel from being converted twice
            WAIT_PEND: begin
                hb_nxt.chsel = `ADC_CH_IDLE;
            end
            default: begin
                hb_nxt = hb;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hb <= '{chsel: `ADC_CH_IDLE, soc: 1'b0, usr_pwd: 1'b1, tsen: 1'b0};
        end else begin
            hb <= hb_nxt;
        end
    end

    assign enter_pwrdwn = ((state_q == GETCMD_W) || (state_q == GETCMD)) &&
                          (state_nxt == PWRDWN);
    assign leave_pwrup  = (state_q == PWRUP_SOC) && (state_nxt != PWRUP_SOC);

    // Each power-down phase starts counting from zero
    assign timer_clr = enter_pwrdwn || ((state_q == PWRDWN) && (state_nxt == PWRDWN_TSEN));
    assign timer_inc = (state_q == PWRDWN) || (state_q == PWRDWN_TSEN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_q <= '0;
        end else if (timer_clr) begin
            timer_q <= '0;
        end else if (timer_inc) begin
            timer_q <= timer_q + 1'b1;
        end
    end

    // The command that forced the power-down is served right after power-up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_fetched <= 1'b0;
        end else if (enter_pwrdwn) begin
            cmd_fetched <= 1'b1;
        end else if (leave_pwrup) begin
            cmd_fetched <= 1'b0;
        end
    end

    // pend rises one cycle into PUTRESP, so PUTRESP still sees the older conversion
    // A recalibration passes PUTRESP without CONV_DLY1 and leaves pend alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            conv_done_q <= 1'b0;
            pend        <= 1'b0;
        end else begin
            conv_done_q <= (state_q == CONV_DLY1);
            if (conv_done_q) begin
                pend <= 1'b1;
            end else if (state_q == WAIT_PEND_DLY1) begin
                pend <= 1'b0;
            end
        end
    end

    // dout on this eoc belongs to the previous conversion
    assign sample_due = eoc_fall && (((state_q == CONV) && pend) || (state_q == WAIT_PEND));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_sample <= 1'b0;
        end else begin
            load_sample <= sample_due;
        end
    end

    assign hold_cmd = (state_q == PUTRESP);
    assign load_rsp = ((state_q == PUTRESP) && pend) || (state_q == PUTRESP_PEND);

    // Tracks the mode of the last accepted conversion; recalibrations do not count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_ts <= 1'b0;
        end else if (hold_cmd && !cmd_is_rclb) begin
            last_ts <= cmd_is_ts;
        end
    end

    a_hold_single: assert property (
        @(posedge clk) disable iff (!rst_n) hold_cmd |=> !hold_cmd
    );

    // Every sample reaches the response register exactly one cycle later
    a_sample_then_rsp: assert property (
        @(posedge clk) disable iff (!rst_n) load_rsp == $past(load_sample)
    );

    a_state_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(state_q) && (state_q <= PUTRESP_PEND)
    );

endmodule

//--- verilog/adc_rsp_stage.sv
`timescale 1ns/1ps
`include "adc_ctrl_config.svh"

module adc_rsp_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  adc_ctrl_pkg::adc_cmd_t   cmd,
    input  logic [`ADC_DATA_W-1:0]   dout,
    input  logic                     hold_cmd,
    input  logic                     load_sample,
    input  logic                     load_rsp,
    output logic                     cmd_ready,
    output adc_ctrl_pkg::adc_rsp_t   rsp
);

    import adc_ctrl_pkg::*;

    // The result of a command shows up one conversion later
    // so its channel and packet markers are parked here until then
    adc_cmd_t               held_cmd;
    logic [`ADC_DATA_W-1:0] sample_q;

    always_ff @(posedge clk) begin
        if (hold_cmd) begin
            held_cmd <= cmd;
        end
    end

    // dout is only guaranteed stable for a short window after eoc falls
    always_ff @(posedge clk) begin
        if (load_sample) begin
            sample_q <= dout;
        end
    end

    // The response is built from the previous hold, since hold_cmd
    // may overwrite it on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp <= '0;
        end else if (load_rsp) begin
            rsp.valid   <= 1'b1;
            rsp.channel <= held_cmd.channel;
            rsp.data    <= sample_q;
            rsp.sop     <= held_cmd.sop;
            rsp.eop     <= held_cmd.eop;
        end else begin
            rsp <= '0;
        end
    end

    // Acceptance strobe for the command being captured
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_ready <= 1'b0;
        end else begin
            cmd_ready <= hold_cmd;
        end
    end

    a_rsp_zero_idle: assert property (
        @(posedge clk) disable iff (!rst_n) !rsp.valid |-> (rsp == '0)
    );

endmodule

//--- verilog/adc_ctrl_top.sv
`timescale 1ns/1ps
`include "adc_ctrl_config.svh"

module adc_ctrl_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_valid,
    input  adc_ctrl_pkg::adc_cmd_t     cmd,
    output logic                       cmd_ready,
    output adc_ctrl_pkg::adc_rsp_t     rsp,
    input  logic                       clk_dft,
    input  logic                       eoc,
    input  logic [`ADC_DATA_W-1:0]     dout,
    output adc_ctrl_pkg::adc_hb_ctrl_t hb
);

    // Edge pulses from the hard-block clock domain
    logic dft_rise;
    logic dft_fall;
    logic eoc_fall;

    // Strobes from the sequencer to the response path
    logic hold_cmd;
    logic load_sample;
    logic load_rsp;
    logic last_ts;

    adc_edge_sync u_edge_sync (
        .clk      (clk),
        .rst_n    (rst_n),
        .clk_dft  (clk_dft),
        .eoc      (eoc),
        .dft_rise (dft_rise),
        .dft_fall (dft_fall),
        .eoc_fall (eoc_fall)
    );

    adc_seq_fsm u_seq_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .dft_rise    (dft_rise),
        .dft_fall    (dft_fall),
        .eoc_fall    (eoc_fall),
        .hb          (hb),
        .hold_cmd    (hold_cmd),
        .load_sample (load_sample),
        .load_rsp    (load_rsp),
        .last_ts     (last_ts)
    );

    adc_rsp_stage u_rsp_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .dout        (dout),
        .hold_cmd    (hold_cmd),
        .load_sample (load_sample),
        .load_rsp    (load_rsp),
        .cmd_ready   (cmd_ready),
        .rsp         (rsp)
    );

    // A result is never returned while the block sits in the other sensing mode
    a_rsp_mode_match: assert property (
        @(posedge clk) disable iff (!rst_n) rsp.valid |-> (hb.tsen == last_ts)
    );

endmodule

//--- sim/tb_adc_hardblock.sv
`timescale 1ns/1ps
`include "adc_ctrl_config.svh"

module tb_adc_hardblock (
    input  logic                       clk,
    input  logic                       rst_n,
    input  adc_ctrl_pkg::adc_hb_ctrl_t hb,
    output logic                       clk_dft,
    output logic                       eoc,
    output logic [`ADC_DATA_W-1:0]     dout
);

    logic [2:0]             dft_cnt;
    logic [4:0]             eoc_cnt;
    logic [`ADC_CHAN_W-1:0] conv_chsel;

    // A conversion result is the channel number times 0x81, cut to the sample width
    function automatic logic [`ADC_DATA_W-1:0] conv_code(input logic [`ADC_CHAN_W-1:0] ch);
        conv_code = ch * 'h81;
    endfunction

    // clk_dft runs only while the block is powered up and toggles every 8 clk cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dft_cnt <= '0;
            clk_dft <= 1'b0;
        end else if (hb.usr_pwd) begin
            dft_cnt <= '0;
            clk_dft <= 1'b0;
        end else begin
            dft_cnt <= dft_cnt + 1'b1;
            if (dft_cnt == 3'd7) begin
                clk_dft <= ~clk_dft;
            end
        end
    end

    // Conversions repeat every 32 cycles once soc is high
    // eoc is high for the last 4 cycles of each one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eoc_cnt    <= '0;
            eoc        <= 1'b0;
            dout       <= '0;
            conv_chsel <= `ADC_CH_IDLE;
        end else if (hb.usr_pwd || !hb.soc) begin
            eoc_cnt <= '0;
            eoc     <= 1'b0;
        end else begin
            eoc_cnt <= eoc_cnt + 1'b1;
            if (eoc_cnt == 5'd27) begin
                eoc <= 1'b1;
            end else if (eoc_cnt == 5'd31) begin
                eoc        <= 1'b0;
                // The data out belongs to the channel latched at the previous fall
                dout       <= conv_code(conv_chsel);
                conv_chsel <= hb.chsel;
            end
        end
    end

endmodule

//--- sim/tb_adc_ctrl.sv
`timescale 1ns/1ps
`include "adc_ctrl_config.svh"

module tb_adc_ctrl;

    import adc_ctrl_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                   clk;
    logic                   rst_n;
    logic                   cmd_valid;
    adc_cmd_t               cmd;
    logic                   cmd_ready;
    adc_rsp_t               rsp;
    logic                   clk_dft;
    logic                   eoc;
    logic [`ADC_DATA_W-1:0] dout;
    adc_hb_ctrl_t           hb;

    // Responses seen on the bus, in arrival order
    adc_rsp_t     rsp_q[$];
    int           ready_count;
    int           pwrdn_count;
    logic         pwd_prev;
    adc_hb_ctrl_t accept_hb;
    integer       seed;

    adc_ctrl_top u_adc_ctrl_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .clk_dft   (clk_dft),
        .eoc       (eoc),
        .dout      (dout),
        .hb        (hb)
    );

    tb_adc_hardblock u_hardblock (
        .clk     (clk),
        .rst_n   (rst_n),
        .hb      (hb),
        .clk_dft (clk_dft),
        .eoc     (eoc),
        .dout    (dout)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Outputs are sampled on the falling edge, halfway between DUT updates
    always @(negedge clk) begin
        if (rst_n) begin
            if (rsp.valid) begin
                rsp_q.push_back(rsp);
            end
            if (cmd_ready) begin
                ready_count = ready_count + 1;
            end
            // Each rise of usr_pwd starts one power-down cycle
            if (hb.usr_pwd && !pwd_prev) begin
                pwrdn_count = pwrdn_count + 1;
            end
            pwd_prev = hb.usr_pwd;
        end
    end

    function automatic logic [`ADC_DATA_W-1:0] sample_code(input logic [`ADC_CHAN_W-1:0] ch);
        sample_code = ch * 'h81;
    endfunction

    function automatic adc_cmd_t make_cmd(input logic [`ADC_CHAN_W-1:0] ch,
                                          input logic sop, input logic eop);
        make_cmd.channel = ch;
        make_cmd.sop     = sop;
        make_cmd.eop     = eop;
    endfunction

    function automatic adc_hb_ctrl_t make_hb(input logic [`ADC_CHAN_W-1:0] chsel,
                                             input logic soc, input logic usr_pwd,
                                             input logic tsen);
        make_hb.chsel   = chsel;
        make_hb.soc     = soc;
        make_hb.usr_pwd = usr_pwd;
        make_hb.tsen    = tsen;
    endfunction

    // What the client should get back for a command on this channel
    function automatic adc_rsp_t expected_rsp(input logic [`ADC_CHAN_W-1:0] ch,
                                              input logic sop, input logic eop);
        expected_rsp.valid   = 1'b1;
        expected_rsp.channel = ch;
        expected_rsp.data    = sample_code(ch);
        expected_rsp.sop     = sop;
        expected_rsp.eop     = eop;
    endfunction

    task automatic abort_test(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_rsp(input adc_rsp_t got, input adc_rsp_t exp, input string name);
        if (got !== exp) begin
            abort_test($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_hb(input adc_hb_ctrl_t got, input adc_hb_ctrl_t exp,
                            input string name);
        if (got !== exp) begin
            abort_test($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            abort_test($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // No stray acceptance and no stray response may have shown up
    task automatic confirm_counts(input int exp_ready);
        if (ready_count != exp_ready) begin
            abort_test($sformatf("Expected %0d command acceptances in total but saw %0d",
                                 exp_ready, ready_count));
        end
        if (rsp_q.size() != 0) begin
            abort_test($sformatf("Saw %0d responses that no command asked for", rsp_q.size()));
        end
    endtask

    task automatic confirm_pwrdn(input int exp_cycles);
        if (pwrdn_count != exp_cycles) begin
            abort_test($sformatf("Expected %0d power-down cycles in total but saw %0d",
                                 exp_cycles, pwrdn_count));
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_power_up;
        int waited;
        waited = 0;
        @(negedge clk);
        while (hb.usr_pwd || !hb.soc) begin
            if (waited == TIMEOUT_CYCLES) begin
                abort_test("Timed out waiting for the ADC block to power up");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // Holds the command until cmd_ready and keeps the hb pins seen at acceptance
    task automatic send_cmd(input adc_cmd_t c);
        int waited;
        waited = 0;
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(negedge clk);
        while (!cmd_ready) begin
            if (waited == TIMEOUT_CYCLES) begin
                abort_test("Timed out waiting for cmd_ready");
            end
            waited++;
            @(negedge clk);
        end
        accept_hb = hb;
        @(posedge clk);
        cmd_valid <= 1'b0;
        cmd       <= '0;
    endtask

    task automatic expect_rsp(input adc_rsp_t exp);
        int       waited;
        adc_rsp_t got;
        waited = 0;
        while (rsp_q.size() == 0) begin
            if (waited == TIMEOUT_CYCLES) begin
                abort_test("Timed out waiting for rsp.valid");
            end
            waited++;
            @(posedge clk);
        end
        got = rsp_q.pop_front();
        check_rsp(got, exp, "rsp");
    endtask

    task automatic reset_values;
        @(negedge clk);
        check_bit(cmd_ready, 1'b0, "cmd_ready");
        check_rsp(rsp, '0, "rsp");
        check_hb(hb, make_hb(`ADC_CH_IDLE, 1'b0, 1'b1, 1'b0), "hb");
    endtask

    task automatic single_conversion;
        int ready_before;
        wait_power_up;
        @(posedge clk);
        ready_before = ready_count;
        send_cmd(make_cmd(5'd5, 1'b1, 1'b1));
        check_hb(accept_hb, make_hb(5'd5, 1'b1, 1'b0, 1'b0), "hb");
        expect_rsp(expected_rsp(5'd5, 1'b1, 1'b1));
        idle_cycles(100);
        confirm_counts(ready_before + 1);
    endtask

    // Commands follow each other with no gap so each result rides on the next conversion
    task automatic burst_conversions;
        adc_cmd_t               sent[$];
        adc_cmd_t               c;
        logic [`ADC_CHAN_W-1:0] ch;
        int                     draw;
        int                     ready_before;
        int                     i;
        @(posedge clk);
        ready_before = ready_count;
        for (i = 0; i < 8; i++) begin
            do begin
                draw = $random(seed);
                ch   = draw[4:0];
            end while ((ch == `ADC_CH_TS) || (ch == `ADC_CH_RCLB));
            draw = $random(seed);
            c    = make_cmd(ch, draw[5], draw[6]);
            sent.push_back(c);
            send_cmd(c);
            check_hb(accept_hb, make_hb(ch, 1'b1, 1'b0, 1'b0), "hb");
        end
        for (i = 0; i < 8; i++) begin
            c = sent.pop_front();
            expect_rsp(expected_rsp(c.channel, c.sop, c.eop));
        end
        idle_cycles(100);
        confirm_counts(ready_before + 8);
    endtask

    task automatic temp_sensor_switch;
        int ready_before;
        int pwrdn_before;
        @(posedge clk);
        ready_before = ready_count;
        pwrdn_before = pwrdn_count;
        send_cmd(make_cmd(`ADC_CH_TS, 1'b1, 1'b0));
        check_hb(accept_hb, make_hb(`ADC_CH_TS, 1'b1, 1'b0, 1'b1), "hb");
        confirm_pwrdn(pwrdn_before + 1);
        expect_rsp(expected_rsp(`ADC_CH_TS, 1'b1, 1'b0));
        // Back to normal mode needs another power-down with tsen cleared
        send_cmd(make_cmd(5'd3, 1'b0, 1'b1));
        check_hb(accept_hb, make_hb(5'd3, 1'b1, 1'b0, 1'b0), "hb");
        confirm_pwrdn(pwrdn_before + 2);
        expect_rsp(expected_rsp(5'd3, 1'b0, 1'b1));
        idle_cycles(100);
        confirm_counts(ready_before + 2);
    endtask

    task automatic recal_cycle;
        int ready_before;
        int pwrdn_before;
        @(posedge clk);
        ready_before = ready_count;
        pwrdn_before = pwrdn_count;
        // Enter temperature mode first so a kept tsen is visible
        send_cmd(make_cmd(`ADC_CH_TS, 1'b1, 1'b1));
        expect_rsp(expected_rsp(`ADC_CH_TS, 1'b1, 1'b1));
        send_cmd(make_cmd(`ADC_CH_RCLB, 1'b1, 1'b1));
        check_hb(accept_hb, make_hb(`ADC_CH_IDLE, 1'b1, 1'b0, 1'b1), "hb");
        confirm_pwrdn(pwrdn_before + 2);
        idle_cycles(100);
        confirm_counts(ready_before + 2);
        send_cmd(make_cmd(5'd3, 1'b1, 1'b0));
        check_hb(accept_hb, make_hb(5'd3, 1'b1, 1'b0, 1'b0), "hb");
        confirm_pwrdn(pwrdn_before + 3);
        expect_rsp(expected_rsp(5'd3, 1'b1, 1'b0));
        idle_cycles(100);
        confirm_counts(ready_before + 3);
    endtask

    initial begin
        seed        = 14;
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        ready_count = 0;
        pwrdn_count = 0;
        pwd_prev    = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        reset_values;
        single_conversion;
        burst_conversions;
        temp_sensor_switch;
        recal_cycle;

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
verilog/adc_ctrl_pkg.sv
verilog/adc_edge_sync.sv
verilog/adc_seq_fsm.sv
verilog/adc_rsp_stage.sv
verilog/adc_ctrl_top.sv
sim/tb_adc_hardblock.sv
sim/tb_adc_ctrl.sv

//--- Bender.yml
package:
  name: adc_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/adc_ctrl_pkg.sv
      - verilog/adc_edge_sync.sv
      - verilog/adc_seq_fsm.sv
      - verilog/adc_rsp_stage.sv
      - verilog/adc_ctrl_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_adc_hardblock.sv
      - sim/tb_adc_ctrl.sv
